// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

  localparam int PAGE_BITS = 6;
  localparam int NUM_REGS  = 16;
  localparam int NPAGES    = 1 << (cpu_pkg::ADDR_W - PAGE_BITS);
  localparam int NUM_TESTS = 6;
  localparam int RUN_LIMIT = 3000;  // cycles allowed for one program

  logic            clka = 1'b0;
  logic            rst;
  logic            run;
  logic            host_we;
  cpu_pkg::paddr_t host_addr;
  cpu_pkg::word_t  host_wdata;
  cpu_pkg::word_t  host_rdata;
  logic            halted;
  logic            fault;

  integer          seed;
  int              errors;
  int              checks;
  int              tests;
  cpu_pkg::word_t  code [$];               // program body from logical 64
  cpu_pkg::word_t  model_ram [1024];       // expected RAM contents
  bit              known [1024];           // written at least once
  cpu_pkg::word_t  model_regs [NUM_REGS];
  bit              pt_valid [NPAGES];
  int              pt_owner [NPAGES];      // logical page per physical page

  cpu_top #(.PAGE_BITS(PAGE_BITS), .NUM_REGS(NUM_REGS)) uut (
    .clka(clka), .rst(rst), .run(run), .host_we(host_we), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_rdata(host_rdata), .halted(halted), .fault(fault)
  );

  always #20 clka = ~clka;

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic int rnd(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic void emit(input logic [7:0] op, input logic [7:0] rn,
                               input cpu_pkg::word_t opnd);
    code.push_back({op, rn});
    code.push_back(opnd);
  endfunction

  task automatic host_write(input cpu_pkg::paddr_t a, input cpu_pkg::word_t d);
    @(posedge clka);
    #2 host_we = 1'b1;
    host_addr  = a;
    host_wdata = d;
    model_ram[a] = d;
    known[a]     = 1'b1;
  endtask

  task automatic host_idle();
    @(posedge clka);
    #2 host_we = 1'b0;  // last write lands at this edge
  endtask

  task automatic host_read(input cpu_pkg::paddr_t a, output cpu_pkg::word_t d);
    @(posedge clka);
    #2 host_addr = a;
    @(posedge clka);
    #1 d = host_rdata;
  endtask

  task automatic apply_reset();
    @(posedge clka);
    #2 rst = 1'b0;
    repeat (8) @(posedge clka);
    #2 rst = 1'b1;
  endtask

  // page table lookup, lowest free page on a miss
  function automatic bit translate(input cpu_pkg::word_t la, output cpu_pkg::paddr_t pa);
    int lpage;
    int pp;
    lpage = int'(la >> PAGE_BITS);
    pp    = -1;
    for (int i = 0; i < NPAGES; i++) begin
      if (pt_valid[i] && pt_owner[i] == lpage && pp < 0) pp = i;
    end
    for (int i = 0; i < NPAGES; i++) begin
      if (pp < 0 && !pt_valid[i]) begin
        pt_valid[i] = 1'b1;
        pt_owner[i] = lpage;
        pp          = i;
      end
    end
    pa = cpu_pkg::paddr_t'((pp << PAGE_BITS) | (la & ((1 << PAGE_BITS) - 1)));
    return pp >= 0;
  endfunction

  task automatic model_execute(input cpu_pkg::word_t head, input cpu_pkg::word_t opnd,
                               inout cpu_pkg::word_t pc, inout bit stop);
    cpu_pkg::paddr_t pa;
    int              r;
    r = int'(head[7:0]) % NUM_REGS;  // register number folded into range
    case (head[15:8])
      cpu_pkg::JMP: pc = opnd;
      cpu_pkg::RAM2REG: begin
        if (translate(opnd, pa)) model_regs[r] = model_ram[pa];
        else stop = 1'b1;
      end
      cpu_pkg::REG2RAM: begin
        if (translate(opnd, pa)) begin
          model_ram[pa] = model_regs[r];
          known[pa]     = 1'b1;
        end else begin
          stop = 1'b1;  // out of pages, nothing stored
        end
      end
      cpu_pkg::NUM2REG:   model_regs[r] = opnd;
      cpu_pkg::REG_PLUS:  model_regs[r] = model_regs[r] + opnd;
      cpu_pkg::REG_MINUS: model_regs[r] = model_regs[r] - opnd;
      cpu_pkg::EXIT:      stop = 1'b1;
      default: ;
    endcase
  endtask

  task automatic model_run();
    cpu_pkg::word_t  pc;
    cpu_pkg::word_t  head;
    cpu_pkg::paddr_t pa;
    bit              stop;
    pc   = '0;
    stop = 1'b0;
    for (int i = 0; i < NPAGES; i++) pt_valid[i] = (i == 0);
    pt_owner[0] = 0;  // logical 0 on physical 0
    for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
    for (int n = 0; n < 200 && !stop; n++) begin
      stop = !translate(pc, pa);
      head = model_ram[pa];
      if (!stop) stop = !translate(pc + 16'd1, pa);
      if (!stop) begin
        pc = pc + 16'd2;
        model_execute(head, model_ram[pa], pc, stop);
      end
    end
  endtask

  task automatic check_ram();
    cpu_pkg::word_t d;
    for (int a = 0; a < 1024; a++) begin
      if (known[a]) begin
        host_read(cpu_pkg::paddr_t'(a), d);
        check_value($sformatf("host_rdata[%03h]", a), d, model_ram[a]);
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) $display("test %-10s passed", name);
    else $display("test %-10s failed with %0d errors", name, errors - err_before);
  endtask

  task automatic execute_test(input string name, input bit exp_fault);
    int e;
    int cycles;
    e = errors;
    apply_reset();
    host_write('0, {cpu_pkg::JMP, 8'h00});  // entry jumps to the code page
    host_write(10'd1, 16'd64);
    foreach (code[k]) host_write(cpu_pkg::paddr_t'(64 + k), code[k]);
    host_idle();
    model_run();
    @(posedge clka);
    #2 run = 1'b1;
    cycles = 0;
    do begin
      @(posedge clka);
      #1 cycles++;
    end while (!halted && cycles < RUN_LIMIT);
    #1 run = 1'b0;
    if (!halted) begin
      errors++;
      $display("test %s: core did not halt within %0d cycles", name, RUN_LIMIT);
    end
    check_value("fault", fault, exp_fault);
    check_ram();
    report_test(name, e);
  endtask

  initial begin
    int lp;
    int r;
    seed = 16;
    rst = 1'b0;
    run = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    errors = 0;
    checks = 0;
    tests = 0;
    repeat (8) @(posedge clka);
    #2 rst = 1'b1;

    for (int i = 0; i < 64; i++) host_write(cpu_pkg::paddr_t'(rnd(1024)), 16'($random(seed)));
    host_idle();
    check_ram();
    report_test("host", 0);

    code.delete();  // alu ops, then every register to page 0
    for (int i = 0; i < 15; i++) emit(8'd4 + 8'(rnd(3)), 8'(rnd(256)), 16'($random(seed)));
    for (int i = 0; i < NUM_REGS; i++) emit(cpu_pkg::REG2RAM, 8'(i + 16 * rnd(16)), 16'(32 + i));
    emit(cpu_pkg::EXIT, 8'h00, 16'h0000);
    execute_test("arith", 1'b0);

    for (int a = 2; a < 32; a++) host_write(cpu_pkg::paddr_t'(a), 16'($random(seed)));
    host_idle();
    code.delete();
    for (int i = 0; i < 15; i++) begin
      r = rnd(NUM_REGS);
      emit(cpu_pkg::RAM2REG, 8'(r), 16'(2 + rnd(30)));
      emit(cpu_pkg::REG2RAM, 8'(r), 16'(32 + rnd(32)));
    end
    emit(cpu_pkg::EXIT, 8'h00, 16'h0000);
    execute_test("load_store", 1'b0);

    code.delete();
    for (int b = 0; b < 4; b++) begin
      lp = 1 + rnd(2);  // instructions to skip
      emit(cpu_pkg::NUM2REG, 8'(rnd(8)), 16'($random(seed)));
      emit(cpu_pkg::JMP, 8'h00, 16'(64 + code.size() + 2 + 2 * lp));
      for (int i = 0; i < lp; i++) emit(cpu_pkg::NUM2REG, 8'(rnd(8)), 16'($random(seed)));
    end
    for (int i = 0; i < 8; i++) emit(cpu_pkg::REG2RAM, 8'(i), 16'(40 + i));
    emit(cpu_pkg::EXIT, 8'h00, 16'h0000);
    execute_test("jump", 1'b0);

    code.delete();
    lp = 2;
    for (int i = 0; i < 10; i++) begin
      if (rnd(3) != 0) lp = 2 + rnd(1022);  // else same page again
      emit(cpu_pkg::NUM2REG, 8'(i), 16'($random(seed)));
      emit(cpu_pkg::REG2RAM, 8'(i), 16'((lp << PAGE_BITS) + rnd(1 << PAGE_BITS)));
    end
    emit(cpu_pkg::EXIT, 8'h00, 16'h0000);
    execute_test("pages", 1'b0);

    code.delete();  // one distinct page more than the free ones
    for (int i = 0; i < NPAGES - 1; i++) begin
      lp = 2 + 16 * i + rnd(16);
      emit(cpu_pkg::REG_PLUS, 8'd1, 16'($random(seed)));
      emit(cpu_pkg::REG2RAM, 8'd1, 16'((lp << PAGE_BITS) + rnd(1 << PAGE_BITS)));
    end
    emit(cpu_pkg::EXIT, 8'h00, 16'h0000);
    execute_test("exhaust", 1'b1);

    $display("finished %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * 4000) @(posedge clka);
    $display("watchdog: run did not finish within %0d clock cycles", NUM_TESTS * 4000);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
  parameter int NUM_REGS = 16
) (
  input  logic               clka,
  input  logic               rst,
  input  logic               run,
  output cpu_pkg::mmu_req_t  mmu_req,
  input  cpu_pkg::mmu_resp_t mmu_resp,
  output cpu_pkg::mem_req_t  mem_req,
  input  cpu_pkg::word_t     rdata,
  output cpu_pkg::reg_wr_t   reg_wr,
  output logic [3:0]         reg_rd_idx,
  input  cpu_pkg::word_t     reg_rd_data,
  output logic               halted
);

  typedef enum logic [3:0] {
    S_HEAD_XLATE,
    S_HEAD_WAIT,
    S_HEAD_READ,
    S_OPND_XLATE,
    S_OPND_WAIT,
    S_OPND_READ,
    S_EXEC,
    S_DATA_XLATE,
    S_DATA_WAIT,
    S_LOAD,
    S_HALT
  } state_t;

  state_t              state;
  cpu_pkg::word_t      pc;         // logical program counter
  cpu_pkg::inst_word_u head_q;     // opcode and register number
  cpu_pkg::word_t      opnd_q;     // second instruction word
  logic [3:0]          reg_idx;
  logic                xlate_ok;   // answer without fault
  logic                xlate_open; // request sent, answer not yet back

  assign reg_idx  = 4'(head_q.head.reg_num % NUM_REGS);  // only the low bits matter
  assign xlate_ok = mmu_resp.done && !mmu_resp.fault;
  assign halted   = (state == S_HALT);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= S_HEAD_XLATE;
      pc    <= '0;
    end else begin
      case (state)
        S_HEAD_XLATE: if (run) state <= S_HEAD_WAIT;  // idle until run
        S_HEAD_WAIT: begin
          if (mmu_resp.done) state <= mmu_resp.fault ? S_HALT : S_HEAD_READ;
        end
        S_HEAD_READ: begin
          head_q.raw <= rdata;
          pc         <= pc + 1'b1;
          state      <= S_OPND_XLATE;
        end
        S_OPND_XLATE: state <= S_OPND_WAIT;
        S_OPND_WAIT: begin
          if (mmu_resp.done) state <= mmu_resp.fault ? S_HALT : S_OPND_READ;
        end
        S_OPND_READ: begin
          opnd_q <= rdata;
          pc     <= pc + 1'b1;
          state  <= S_EXEC;
        end
        S_EXEC: begin
          case (head_q.head.op)
            cpu_pkg::JMP: begin
              pc    <= opnd_q;
              state <= S_HEAD_XLATE;
            end
            cpu_pkg::RAM2REG, cpu_pkg::REG2RAM: state <= S_DATA_XLATE;
            cpu_pkg::EXIT: state <= S_HALT;
            default: state <= S_HEAD_XLATE;  // alu ops and no-ops
          endcase
        end
        S_DATA_XLATE: state <= S_DATA_WAIT;
        S_DATA_WAIT: begin
          if (mmu_resp.done) begin
            if (mmu_resp.fault) begin
              state <= S_HALT;
            end else if (head_q.head.op == cpu_pkg::RAM2REG) begin
              state <= S_LOAD;
            end else begin
              state <= S_HEAD_XLATE;  // store lands at this edge
            end
          end
        end
        S_LOAD: state <= S_HEAD_XLATE;
        default: state <= S_HALT;  // stays until reset
      endcase
    end
  end

  // translation requests with the address held through the wait state
  always_comb begin
    mmu_req.valid = ((state == S_HEAD_XLATE) && run) ||
                    (state == S_OPND_XLATE) || (state == S_DATA_XLATE);
    if ((state == S_DATA_XLATE) || (state == S_DATA_WAIT)) begin
      mmu_req.laddr = opnd_q;
    end else begin
      mmu_req.laddr = pc;
    end
  end

  // memory access issued in the cycle the translation returns
  always_comb begin
    mem_req       = '0;
    mem_req.addr  = mmu_resp.phys_addr;
    mem_req.wdata = reg_rd_data;
    if ((state == S_HEAD_WAIT) || (state == S_OPND_WAIT)) begin
      mem_req.en = xlate_ok;
    end else if (state == S_DATA_WAIT) begin
      mem_req.en = xlate_ok;
      mem_req.we = xlate_ok && (head_q.head.op == cpu_pkg::REG2RAM);
    end
  end

  assign reg_rd_idx = reg_idx;

  always_comb begin
    reg_wr     = '0;
    reg_wr.idx = reg_idx;
    if (state == S_EXEC) begin
      case (head_q.head.op)
        cpu_pkg::NUM2REG: begin
          reg_wr.en   = 1'b1;
          reg_wr.data = opnd_q;
        end
        cpu_pkg::REG_PLUS: begin
          reg_wr.en   = 1'b1;
          reg_wr.data = reg_rd_data + opnd_q;  // wraps at 16 bits
        end
        cpu_pkg::REG_MINUS: begin
          reg_wr.en   = 1'b1;
          reg_wr.data = reg_rd_data - opnd_q;
        end
        default: reg_wr.en = 1'b0;
      endcase
    end else if (state == S_LOAD) begin
      reg_wr.en   = 1'b1;
      reg_wr.data = rdata;  // read issued in data wait
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      xlate_open <= 1'b0;
    end else if (mmu_req.valid) begin
      xlate_open <= 1'b1;
    end else if (mmu_resp.done) begin
      xlate_open <= 1'b0;
    end
  end

  // one translation at a time
  a_one_xlate: assert property (@(posedge clka) disable iff (!rst)
    xlate_open |-> !mmu_req.valid)
    else $error("translation requested while another was pending");

endmodule

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

  localparam int DATA_W = 16;  // data word width
  localparam int ADDR_W = 10;  // 1024 words of RAM

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] paddr_t;

  // opcodes kept from the full instruction set
  typedef enum logic [7:0] {
    JMP       = 8'd1,   // pc <= operand
    RAM2REG   = 8'd2,   // reg <= mem[operand]
    REG2RAM   = 8'd3,   // mem[operand] <= reg
    NUM2REG   = 8'd4,   // reg <= operand
    REG_PLUS  = 8'd5,   // reg += operand
    REG_MINUS = 8'd6,   // reg -= operand
    EXIT      = 8'd17   // stop the core
  } opcode_e;

  // first word of every instruction
  typedef struct packed {
    opcode_e    op;       // upper byte
    logic [7:0] reg_num;  // lower byte
  } inst_head_t;

  // a fetched word is either plain data or an instruction head
  typedef union packed {
    word_t      raw;
    inst_head_t head;
  } inst_word_u;

  // core side of the RAM
  typedef struct packed {
    logic   en;
    logic   we;
    paddr_t addr;
    word_t  wdata;
  } mem_req_t;

  // logical address to translate
  typedef struct packed {
    logic  valid;  // one-cycle strobe
    word_t laddr;
  } mmu_req_t;

  typedef struct packed {
    logic   done;       // one-cycle pulse
    logic   fault;      // sticky until reset
    paddr_t phys_addr;
  } mmu_resp_t;

  typedef struct packed {
    logic       en;
    logic [3:0] idx;   // wide enough for 16 registers
    word_t      data;
  } reg_wr_t;

endpackage

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
  parameter int PAGE_BITS = 6,   // 64-word pages
  parameter int NUM_REGS  = 16
) (
  input  logic            clka,
  input  logic            rst,
  input  logic            run,
  input  logic            host_we,
  input  cpu_pkg::paddr_t host_addr,
  input  cpu_pkg::word_t  host_wdata,
  output cpu_pkg::word_t  host_rdata,
  output logic            halted,
  output logic            fault
);

  cpu_pkg::mmu_req_t  mmu_req;
  cpu_pkg::mmu_resp_t mmu_resp;
  cpu_pkg::mem_req_t  mem_req;
  cpu_pkg::word_t     mem_rdata;
  cpu_pkg::reg_wr_t   reg_wr;
  logic [3:0]         reg_rd_idx;
  cpu_pkg::word_t     reg_rd_data;

  assign fault = mmu_resp.fault;  // sticky level from the translator

  cpu_core #(.NUM_REGS(NUM_REGS)) u_core (
    .clka        (clka),
    .rst         (rst),
    .run         (run),
    .mmu_req     (mmu_req),
    .mmu_resp    (mmu_resp),
    .mem_req     (mem_req),
    .rdata       (mem_rdata),
    .reg_wr      (reg_wr),
    .reg_rd_idx  (reg_rd_idx),
    .reg_rd_data (reg_rd_data),
    .halted      (halted)
  );

  reg_file #(.NUM_REGS(NUM_REGS)) u_regs (
    .clka    (clka),
    .rst     (rst),
    .wr      (reg_wr),
    .rd_idx  (reg_rd_idx),
    .rd_data (reg_rd_data)
  );

  page_mmu #(.PAGE_BITS(PAGE_BITS)) u_mmu (
    .clka (clka),
    .rst  (rst),
    .req  (mmu_req),
    .resp (mmu_resp)
  );

  program_memory u_mem (
    .clka       (clka),
    .run        (run),
    .req        (mem_req),
    .rdata      (mem_rdata),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

endmodule

// ==== hdl/page_mmu.sv ====
`timescale 1ns/1ps

module page_mmu #(
  parameter int PAGE_BITS = 6
) (
  input  logic               clka,
  input  logic               rst,
  input  cpu_pkg::mmu_req_t  req,
  output cpu_pkg::mmu_resp_t resp
);

  localparam int PPAGE_W = cpu_pkg::ADDR_W - PAGE_BITS;  // physical page index
  localparam int LPAGE_W = cpu_pkg::DATA_W - PAGE_BITS;  // logical page index
  localparam int NPAGES  = 1 << PPAGE_W;

  typedef enum logic [1:0] {
    IDLE,
    SCAN,
    ALLOC,
    DEAD
  } state_t;

  state_t               state;
  logic [NPAGES-1:0]    tbl_valid;             // page in use
  logic [LPAGE_W-1:0]   tbl_owner [NPAGES];    // logical page held there
  logic [LPAGE_W-1:0]   last_lpage;
  logic [PPAGE_W-1:0]   last_ppage;
  logic [LPAGE_W-1:0]   lpage_q;
  logic [PAGE_BITS-1:0] offset_q;
  logic [PPAGE_W-1:0]   scan_idx;
  logic [PPAGE_W-1:0]   free_idx;              // lowest free page seen
  logic                 free_found;
  logic [PPAGE_W-1:0]   phys_page_q;
  logic                 done_q;
  logic                 fault_q;
  logic                 open_q;                // request outstanding
  logic                 hit;

  assign hit = (req.laddr[cpu_pkg::DATA_W-1:PAGE_BITS] == last_lpage);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state        <= IDLE;
      tbl_valid    <= NPAGES'(1);  // page 0 preallocated
      tbl_owner[0] <= '0;
      last_lpage   <= '0;          // logical 0 maps to physical 0
      last_ppage   <= '0;
      scan_idx     <= '0;
      free_found   <= 1'b0;
      done_q       <= 1'b0;
      fault_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        IDLE: begin
          if (req.valid) begin
            lpage_q  <= req.laddr[cpu_pkg::DATA_W-1:PAGE_BITS];
            offset_q <= req.laddr[PAGE_BITS-1:0];
            if (hit) begin
              done_q      <= 1'b1;  // reuse last translation
              phys_page_q <= last_ppage;
            end else begin
              scan_idx   <= '0;
              free_found <= 1'b0;
              state      <= SCAN;
            end
          end
        end
        SCAN: begin
          if (tbl_valid[scan_idx] && (tbl_owner[scan_idx] == lpage_q)) begin
            done_q      <= 1'b1;
            phys_page_q <= scan_idx;
            last_lpage  <= lpage_q;
            last_ppage  <= scan_idx;
            state       <= IDLE;
          end else begin
            if (!tbl_valid[scan_idx] && !free_found) begin
              free_found <= 1'b1;
              free_idx   <= scan_idx;
            end
            if (scan_idx == PPAGE_W'(NPAGES - 1)) begin
              state <= ALLOC;  // whole table missed
            end else begin
              scan_idx <= scan_idx + 1'b1;
            end
          end
        end
        ALLOC: begin
          done_q <= 1'b1;
          if (free_found) begin
            tbl_valid[free_idx] <= 1'b1;
            tbl_owner[free_idx] <= lpage_q;
            phys_page_q         <= free_idx;
            last_lpage          <= lpage_q;
            last_ppage          <= free_idx;
            state               <= IDLE;
          end else begin
            fault_q <= 1'b1;  // out of pages
            state   <= DEAD;
          end
        end
        default: state <= DEAD;  // wait for reset
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      open_q <= 1'b0;
    end else if (req.valid) begin
      open_q <= 1'b1;
    end else if (done_q) begin
      open_q <= 1'b0;
    end
  end

  assign resp.done      = done_q;
  assign resp.fault     = fault_q;
  assign resp.phys_addr = {phys_page_q, offset_q};  // page index then offset

  a_done_after_valid: assert property (@(posedge clka) disable iff (!rst)
    resp.done |-> open_q)
    else $error("translation answer without a request");

endmodule

// ==== hdl/program_memory.sv ====
`timescale 1ns/1ps

module program_memory (
  input  logic              clka,
  input  logic              run,
  input  cpu_pkg::mem_req_t req,
  output cpu_pkg::word_t    rdata,
  input  logic              host_we,
  input  cpu_pkg::paddr_t   host_addr,
  input  cpu_pkg::word_t    host_wdata,
  output cpu_pkg::word_t    host_rdata
);

  cpu_pkg::word_t  ram [1 << cpu_pkg::ADDR_W];
  cpu_pkg::paddr_t addr;
  cpu_pkg::word_t  wdata;
  logic            we;
  logic            rd_en;
  cpu_pkg::word_t  dout_q;

  // single port, owner picked by run
  assign addr  = run ? req.addr : host_addr;
  assign wdata = run ? req.wdata : host_wdata;
  assign we    = run ? (req.en && req.we) : host_we;
  assign rd_en = run ? req.en : 1'b1;  // host reads every cycle

  always_ff @(posedge clka) begin
    if (we) begin
      ram[addr] <= wdata;
    end
    if (rd_en) begin
      dout_q <= ram[addr];  // old data on a write
    end
  end

  assign rdata      = dout_q;
  assign host_rdata = dout_q;

  // host writes are only allowed while the core is stopped
  a_host_idle: assert property (@(posedge clka) run |-> !host_we)
    else $error("host write while the core is running");

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
  parameter int NUM_REGS = 16
) (
  input  logic             clka,
  input  logic             rst,
  input  cpu_pkg::reg_wr_t wr,
  input  logic [3:0]       rd_idx,
  output cpu_pkg::word_t   rd_data
);

  cpu_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en) begin
      regs[wr.idx] <= wr.data;  // visible from the next cycle
    end
  end

  // combinational read port
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (rd_idx == 4'(i)) begin
        rd_data = regs[i];
      end
    end
  end

  // the core must fold register numbers into the implemented range
  a_wr_idx: assert property (@(posedge clka) disable iff (!rst)
    wr.en |-> (int'(wr.idx) < NUM_REGS))
    else $error("register write index %0d out of range", wr.idx);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f sim.f -o cpu_tb_sim
out=$(./obj_dir/cpu_tb_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

// ==== sim.f ====
hdl/cpu_pkg.sv
hdl/reg_file.sv
hdl/page_mmu.sv
hdl/program_memory.sv
hdl/cpu_core.sv
hdl/cpu_top.sv
dv/cpu_tb.sv
